// ==== mul16_params.svh ====
// Width and latency macros for the pipelined 16x16 multiplier
`ifndef MUL16_PARAMS_SVH
`define MUL16_PARAMS_SVH

// Operand and byte widths
`define MUL_OPERAND_W 16
`define MUL_HALF_W 8

// Full product, also the adder width
`define MUL_PRODUCT_W 32

// Bits per carry-lookahead group
`define CLA_GROUP_W 4

// Edges from operand capture to product
`define MUL_LATENCY 2

`endif

// ==== mul16_pkg.sv ====
// Vector typedefs for operands, operand bytes, quadrant products and full products
package mul16_pkg;

  // One multiplier operand
  typedef logic [15:0] operand_t;

  // High or low byte of an operand
  typedef logic [7:0] half_t;

  // Product of two operand bytes
  typedef logic [15:0] half_prod_t;

  // Full product, same width as the lookahead adders
  typedef logic [31:0] product_t;

endpackage

// ==== array_mult8.sv ====
// Exact 8x8 unsigned carry-save array multiplier with a final ripple row
`timescale 1ns/1ps
`include "mul16_params.svh"

module array_mult8 (
  input  mul16_pkg::half_t      a,
  input  mul16_pkg::half_t      b,
  output mul16_pkg::half_prod_t p
);

  import mul16_pkg::*;

  // Partial product rows, row i weighted by b[i]
  half_t pp [`MUL_HALF_W];

  // Sum and carry outputs of each array row
  half_t s [`MUL_HALF_W];
  half_t c [1:`MUL_HALF_W-1];

  // Previous row sums moved one column down
  half_t up [1:`MUL_HALF_W-1];

  // Carries of the final ripple row
  logic [`MUL_HALF_W-2:0] r;

  for (genvar i = 0; i < `MUL_HALF_W; i++) begin : g_pp
    assign pp[i] = a & {`MUL_HALF_W{b[i]}};
  end

  // First row passes straight through
  assign s[0] = pp[0];

  for (genvar i = 1; i < `MUL_HALF_W; i++) begin : g_row
    assign up[i] = s[i-1] >> 1;

    for (genvar j = 0; j < `MUL_HALF_W; j++) begin : g_col
      if (i == 1) begin : g_ha
        // No carries yet, half adders suffice
        assign s[i][j] = pp[i][j] ^ up[i][j];
        assign c[i][j] = pp[i][j] & up[i][j];
      end else begin : g_fa
        assign s[i][j] = pp[i][j] ^ up[i][j] ^ c[i-1][j];
        assign c[i][j] = (pp[i][j] & up[i][j]) |
                         (c[i-1][j] & (pp[i][j] ^ up[i][j]));
      end
    end
  end

  // Low byte falls out of column 0 of every row
  for (genvar i = 0; i < `MUL_HALF_W; i++) begin : g_low
    assign p[i] = s[i][0];
  end

  // Ripple row resolves remaining sums and carries into the upper byte
  for (genvar k = 0; k < `MUL_HALF_W; k++) begin : g_rip
    if (k == 0) begin : g_ha
      assign p[`MUL_HALF_W+k] = s[`MUL_HALF_W-1][k+1] ^ c[`MUL_HALF_W-1][k];
      assign r[k]             = s[`MUL_HALF_W-1][k+1] & c[`MUL_HALF_W-1][k];
    end else if (k < `MUL_HALF_W - 1) begin : g_fa
      assign p[`MUL_HALF_W+k] = s[`MUL_HALF_W-1][k+1] ^ c[`MUL_HALF_W-1][k] ^ r[k-1];
      assign r[k] = (s[`MUL_HALF_W-1][k+1] & c[`MUL_HALF_W-1][k]) |
                    (r[k-1] & (s[`MUL_HALF_W-1][k+1] ^ c[`MUL_HALF_W-1][k]));
    end else begin : g_msb
      // Product fits in 16 bits, so no carry leaves this column
      assign p[`MUL_HALF_W+k] = c[`MUL_HALF_W-1][k] ^ r[k-1];
    end
  end

endmodule

// ==== cla_adder32.sv ====
// 32-bit carry-lookahead adder with four-bit groups and a group-carry unit
`timescale 1ns/1ps
`include "mul16_params.svh"

module cla_adder32 (
  input  mul16_pkg::product_t a,
  input  mul16_pkg::product_t b,
  output mul16_pkg::product_t sum
);

  import mul16_pkg::*;

  localparam int num_groups = `MUL_PRODUCT_W / `CLA_GROUP_W;

  // Bitwise propagate and generate
  product_t p;
  product_t g;

  // Group propagate, group generate and carry into each group
  logic [num_groups-1:0] gp;
  logic [num_groups-1:0] gg;
  logic [num_groups-1:0] gc;

  assign p = a ^ b;
  assign g = a & b;

  for (genvar k = 0; k < num_groups; k++) begin : g_group
    localparam int base = k * `CLA_GROUP_W;

    // Local carries inside the group
    logic [`CLA_GROUP_W-1:0] lc;

    assign gp[k] = p[base+3] & p[base+2] & p[base+1] & p[base];
    assign gg[k] = g[base+3] |
                   (p[base+3] & g[base+2]) |
                   (p[base+3] & p[base+2] & g[base+1]) |
                   (p[base+3] & p[base+2] & p[base+1] & g[base]);

    assign lc[0] = gc[k];
    assign lc[1] = g[base] | (p[base] & lc[0]);
    assign lc[2] = g[base+1] |
                   (p[base+1] & g[base]) |
                   (p[base+1] & p[base] & lc[0]);
    assign lc[3] = g[base+2] |
                   (p[base+2] & g[base+1]) |
                   (p[base+2] & p[base+1] & g[base]) |
                   (p[base+2] & p[base+1] & p[base] & lc[0]);

    assign sum[base +: `CLA_GROUP_W] = p[base +: `CLA_GROUP_W] ^ lc;
  end

  // Second-level lookahead, each group carry as a flat sum of products
  always_comb begin : group_carry
    logic term;
    term  = 1'b0;
    gc[0] = 1'b0;
    for (int k = 1; k < num_groups; k++) begin
      gc[k] = 1'b0;
      for (int j = 0; j < k; j++) begin
        term = gg[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & gp[m];
        end
        gc[k] = gc[k] | term;
      end
    end
  end

endmodule

// ==== quad_product_stage.sv ====
// First pipeline stage, byte split, four quadrant multipliers and their registers
`timescale 1ns/1ps
`include "mul16_params.svh"

module quad_product_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mul16_pkg::operand_t   op_a,
  input  mul16_pkg::operand_t   op_b,
  output mul16_pkg::half_prod_t prod_ll,
  output mul16_pkg::half_prod_t prod_lh,
  output mul16_pkg::half_prod_t prod_hl,
  output mul16_pkg::half_prod_t prod_hh
);

  import mul16_pkg::*;

  half_t a_lo;
  half_t a_hi;
  half_t b_lo;
  half_t b_hi;

  // Combinational quadrant products
  half_prod_t ll_d;
  half_prod_t lh_d;
  half_prod_t hl_d;
  half_prod_t hh_d;

  assign a_lo = op_a[`MUL_HALF_W-1:0];
  assign a_hi = op_a[`MUL_OPERAND_W-1:`MUL_HALF_W];
  assign b_lo = op_b[`MUL_HALF_W-1:0];
  assign b_hi = op_b[`MUL_OPERAND_W-1:`MUL_HALF_W];

  array_mult8 mult_ll (.a(a_lo), .b(b_lo), .p(ll_d));
  array_mult8 mult_lh (.a(a_lo), .b(b_hi), .p(lh_d));
  array_mult8 mult_hl (.a(a_hi), .b(b_lo), .p(hl_d));
  array_mult8 mult_hh (.a(a_hi), .b(b_hi), .p(hh_d));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_ll <= '0;
      prod_lh <= '0;
      prod_hl <= '0;
      prod_hh <= '0;
    end else begin
      prod_ll <= ll_d;
      prod_lh <= lh_d;
      prod_hl <= hl_d;
      prod_hh <= hh_d;
    end
  end

  // A zero multiplicand clears every quadrant on the next cycle
  a_zero_clears_quadrants: assert property (
    @(posedge clk) disable iff (!rst_n)
    (op_a == '0) |=> (prod_ll == '0 && prod_lh == '0 &&
                      prod_hl == '0 && prod_hh == '0)
  );

endmodule

// ==== product_sum_stage.sv ====
// Second pipeline stage, quadrant alignment, two lookahead adders and the product register
`timescale 1ns/1ps
`include "mul16_params.svh"

module product_sum_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mul16_pkg::half_prod_t prod_ll,
  input  mul16_pkg::half_prod_t prod_lh,
  input  mul16_pkg::half_prod_t prod_hl,
  input  mul16_pkg::half_prod_t prod_hh,
  output mul16_pkg::product_t   product
);

  import mul16_pkg::*;

  // High-high above low-low, no overlap
  product_t hh_ll_word;

  // Cross terms moved up one byte
  product_t cross_lh;
  product_t cross_hl;

  product_t mid_sum;
  product_t product_d;

  assign hh_ll_word = {prod_hh, prod_ll};
  assign cross_lh   = {{`MUL_HALF_W{1'b0}}, prod_lh, {`MUL_HALF_W{1'b0}}};
  assign cross_hl   = {{`MUL_HALF_W{1'b0}}, prod_hl, {`MUL_HALF_W{1'b0}}};

  cla_adder32 add_cross_lh (.a(hh_ll_word), .b(cross_lh), .sum(mid_sum));
  cla_adder32 add_cross_hl (.a(mid_sum),    .b(cross_hl), .sum(product_d));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      product <= '0;
    end else begin
      product <= product_d;
    end
  end

  // Cross terms never touch the low byte, so it comes from prod_ll alone
  low_byte_from_ll: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> product[`MUL_HALF_W-1:0] == $past(prod_ll[`MUL_HALF_W-1:0])
  );

endmodule

// ==== mul16_top.sv ====
// Top level of the two-stage 16x16 unsigned multiplier
`timescale 1ns/1ps
`include "mul16_params.svh"

module mul16_top (
  input  logic                clk,
  input  logic                rst_n,
  input  mul16_pkg::operand_t op_a,
  input  mul16_pkg::operand_t op_b,
  output mul16_pkg::product_t product
);

  import mul16_pkg::*;

  // Registered quadrant products between the stages
  half_prod_t prod_ll;
  half_prod_t prod_lh;
  half_prod_t prod_hl;
  half_prod_t prod_hh;

  quad_product_stage u_quad (
    .clk     (clk),
    .rst_n   (rst_n),
    .op_a    (op_a),
    .op_b    (op_b),
    .prod_ll (prod_ll),
    .prod_lh (prod_lh),
    .prod_hl (prod_hl),
    .prod_hh (prod_hh)
  );

  product_sum_stage u_sum (
    .clk     (clk),
    .rst_n   (rst_n),
    .prod_ll (prod_ll),
    .prod_lh (prod_lh),
    .prod_hl (prod_hl),
    .prod_hh (prod_hh),
    .product (product)
  );

endmodule

// ==== tb_mul16.sv ====
// Self-checking testbench for the pipelined 16x16 multiplier with stimulus table and random phase
`timescale 1ns/1ps
`include "mul16_params.svh"

module tb_mul16;

  import mul16_pkg::*;

  localparam int clk_period    = 10;
  localparam int reset_cycles  = 5;
  localparam int release_limit = 20;
  localparam int drain_limit   = 10;
  localparam int num_vecs      = 21;
  localparam int num_random    = 200;

  logic     clk;
  logic     rst_n;
  operand_t op_a;
  operand_t op_b;
  product_t product;

  int     error_count;
  int     check_count;
  integer seed;

  // Pairs in flight with the oldest at the front
  operand_t a_q[$];
  operand_t b_q[$];
  product_t exp_q[$];

  // Each entry holds op_a, op_b and the expected product
  logic [63:0] vec_table [num_vecs] = '{
    {16'h0001, 16'hABCD, 32'h0000_ABCD},
    {16'hBEEF, 16'h0001, 32'h0000_BEEF},
    {16'hFFFF, 16'hFFFF, 32'hFFFE_0001},
    {16'h0000, 16'h0000, 32'h0000_0000},
    {16'h0000, 16'hFFFF, 32'h0000_0000},
    {16'h1234, 16'h0000, 32'h0000_0000},
    {16'h8000, 16'h8000, 32'h4000_0000},
    {16'h00FF, 16'h00FF, 32'h0000_FE01},
    {16'hFF00, 16'hFF00, 32'hFE01_0000},
    {16'h00FF, 16'hFF00, 32'h00FE_0100},
    {16'hFF00, 16'h00FF, 32'h00FE_0100},
    {16'hFFFF, 16'h0101, 32'h0100_FEFF},
    {16'h0101, 16'hFFFF, 32'h0100_FEFF},
    {16'hFF01, 16'h01FF, 32'h01FD_02FF},
    {16'h0002, 16'h8000, 32'h0001_0000},
    {16'hFFFF, 16'h0001, 32'h0000_FFFF},
    {16'h00FF, 16'h0101, 32'h0000_FFFF},
    {16'h1234, 16'h5678, 32'h0626_0060},
    {16'hFFFF, 16'h8000, 32'h7FFF_8000},
    {16'h7FFF, 16'h7FFF, 32'h3FFF_0001},
    {16'h8001, 16'hFFFF, 32'h8000_7FFF}
  };

  mul16_top DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .op_a    (op_a),
    .op_b    (op_b),
    .product (product)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic check_product(input string what, input operand_t a, input operand_t b,
                               input product_t expected, input product_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL t=%0t %s: %h x %h expected %h got %h",
               $time, what, a, b, expected, actual);
    end
  endtask

  // Polls rst_n at clock edges until the DUT sees it high
  task automatic wait_for_release();
    int cycles;
    cycles = 0;
    while (cycles < release_limit) begin
      @(posedge clk);
      cycles++;
      if (rst_n === 1'b1) begin
        break;
      end
    end
    if (rst_n !== 1'b1) begin
      error_count++;
      $display("ERROR: reset was not released within %0d cycles", release_limit);
    end
  endtask

  // Checks the pair from two edges back and then drives the next pair
  task automatic apply_pair(input operand_t a, input operand_t b, input product_t expected);
    operand_t old_a;
    operand_t old_b;
    product_t old_exp;
    #1;
    if (a_q.size() >= `MUL_LATENCY) begin
      old_a   = a_q.pop_front();
      old_b   = b_q.pop_front();
      old_exp = exp_q.pop_front();
      check_product("pipeline", old_a, old_b, old_exp, product);
    end else begin
      // Zeros from reset still fill the pipeline
      check_product("startup", 16'h0000, 16'h0000, 32'h0000_0000, product);
    end
    op_a = a;
    op_b = b;
    a_q.push_back(a);
    b_q.push_back(b);
    exp_q.push_back(expected);
    @(posedge clk);
  endtask

  task automatic drain_pipeline();
    int       cycles;
    operand_t old_a;
    operand_t old_b;
    product_t old_exp;
    cycles = 0;
    while (a_q.size() > 0 && cycles < drain_limit) begin
      #1;
      old_a   = a_q.pop_front();
      old_b   = b_q.pop_front();
      old_exp = exp_q.pop_front();
      check_product("drain", old_a, old_b, old_exp, product);
      op_a = '0;
      op_b = '0;
      @(posedge clk);
      cycles++;
    end
    if (a_q.size() > 0) begin
      error_count++;
      $display("ERROR: %0d products still pending after %0d drain cycles",
               a_q.size(), drain_limit);
    end
  endtask

  initial begin : main
    int       i;
    integer   rnd_a;
    integer   rnd_b;
    operand_t a;
    operand_t b;
    product_t expected;

    error_count = 0;
    check_count = 0;
    seed        = 32'h9d23_76d9;
    clk         = 1'b0;
    rst_n       = 1'b0;
    // Nonzero operands show that reset forces a zero product
    op_a        = 16'hFFFF;
    op_b        = 16'hFFFF;

    for (i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      #1;
      check_product("reset", op_a, op_b, 32'h0000_0000, product);
    end
    rst_n = 1'b1;
    op_a  = '0;
    op_b  = '0;
    wait_for_release();

    // Table pairs back to back
    for (i = 0; i < num_vecs; i++) begin
      a        = vec_table[i][63:48];
      b        = vec_table[i][47:32];
      expected = vec_table[i][31:0];
      apply_pair(a, b, expected);
    end

    // Random pairs follow without a gap
    for (i = 0; i < num_random; i++) begin
      rnd_a    = $random(seed);
      rnd_b    = $random(seed);
      a        = rnd_a[15:0];
      b        = rnd_b[15:0];
      expected = {16'h0000, a} * {16'h0000, b};
      apply_pair(a, b, expected);
    end

    drain_pipeline();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
mul16_pkg.sv
array_mult8.sv
cla_adder32.sv
quad_product_stage.sv
product_sum_stage.sv
mul16_top.sv
tb_mul16.sv
